// ==== hw/roce_pkg.sv ====
`default_nettype none

package roce_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [23:0] psn_t;
    typedef logic [23:0] qpn_t;
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [15:0] cnt_t;

    localparam int BEAT_BYTES = 64;  // All headers fit in the first beat

    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [15:0] ROCE_UDP_PORT = 16'd4791;
    localparam qpn_t        QP_BASE       = 24'd2;

    // BTH opcodes, RC transport
    localparam logic [7:0] OP_SEND_ONLY      = 8'h04;
    localparam logic [7:0] OP_WRITE_ONLY     = 8'h0A;
    localparam logic [7:0] OP_READ_RESP_ONLY = 8'h10;
    localparam logic [7:0] OP_ACK            = 8'h11;

    // Byte offsets from start of frame, untagged Ethernet + IPv4 without options
    localparam int OFS_ETH_DST    = 0;
    localparam int OFS_ETH_TYPE   = 12;
    localparam int OFS_IP_DST     = 30;
    localparam int OFS_UDP_DPORT  = 36;
    localparam int OFS_BTH_OPCODE = 42;
    localparam int OFS_BTH_DQP    = 47;
    localparam int OFS_BTH_PSN    = 51;
    localparam int HDR_BYTES      = 54;  // Up to end of BTH

    localparam apb_addr_t REG_CTRL     = 12'h000;
    localparam apb_addr_t REG_MAC_LO   = 12'h004;
    localparam apb_addr_t REG_MAC_HI   = 12'h008;
    localparam apb_addr_t REG_IP       = 12'h00C;
    localparam apb_addr_t REG_PSN_BASE = 12'h040;
    localparam apb_addr_t REG_CNT_BASE = 12'h080;

    localparam int NUM_CLASS = 8;

    typedef enum logic [2:0] {
        NON_ROCE,
        ADDR_DROP,
        SEND,
        WRITE,
        READ_RESP,
        ACK,
        PSN_ERR,
        BAD_QP
    } pkt_class_e;

    typedef struct packed {
        logic [BEAT_BYTES*8-1:0] data;  // Byte 0 in bits 7:0
        logic [BEAT_BYTES-1:0]   keep;
        logic                    last;
    } rx_beat_t;

    typedef struct packed {
        logic       valid;
        pkt_class_e cls;  // Preliminary, before the PSN check
        qpn_t       dest_qp;
        psn_t       psn;
    } hdr_info_t;

    typedef struct packed {
        logic       valid;
        pkt_class_e cls;
        qpn_t       qp;  // BTH destination QP
    } pkt_event_t;

    typedef struct packed {
        logic       enable;
        mac_addr_t  local_mac;
        ipv4_addr_t local_ip;
    } roce_cfg_t;

endpackage

`default_nettype wire

// ==== hw/roce_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module roce_cfg_regs import roce_pkg::*; #(
    parameter int NUM_QP = 6
) (
    input  wire               aclk,
    input  wire               aresetn,
    input  wire               i_psel,
    input  wire               i_penable,
    input  wire               i_pwrite,
    input  wire apb_addr_t    i_paddr,
    input  wire apb_data_t    i_pwdata,
    input  wire cnt_t [NUM_CLASS-1:0] i_cnt,
    output apb_data_t         o_prdata,
    output logic              o_pready,
    output logic              o_pslverr,
    output roce_cfg_t         o_cfg,
    output logic              o_psn_load,
    output logic [2:0]        o_psn_load_qp,
    output psn_t              o_psn_load_val,
    output logic              o_cnt_clear
);

    logic      access;
    logic      wr_en;
    logic      reg_hit;
    logic      psn_hit;
    logic      cnt_hit;
    apb_addr_t psn_ofs;
    apb_addr_t cnt_ofs;
    roce_cfg_t cfg;
    logic      cnt_clear;

    assign access = i_psel & i_penable;
    assign wr_en  = access & i_pwrite;

    assign psn_ofs = i_paddr - REG_PSN_BASE;
    assign cnt_ofs = i_paddr - REG_CNT_BASE;

    // One word per QP, write-only, reads return zero
    assign psn_hit = (i_paddr >= REG_PSN_BASE) && (psn_ofs < apb_addr_t'(4 * NUM_QP))
                     && (i_paddr[1:0] == 2'b00);
    // Counters are read-only
    assign cnt_hit = (i_paddr >= REG_CNT_BASE) && (cnt_ofs < apb_addr_t'(4 * NUM_CLASS))
                     && (i_paddr[1:0] == 2'b00);

    assign reg_hit = (i_paddr == REG_CTRL) || (i_paddr == REG_MAC_LO)
                     || (i_paddr == REG_MAC_HI) || (i_paddr == REG_IP);

    assign o_pready  = 1'b1;  // Zero wait states
    assign o_pslverr = access & ~(reg_hit | psn_hit | (cnt_hit & ~i_pwrite));

    always_comb begin
        o_prdata = '0;
        case (i_paddr)
            REG_CTRL:   o_prdata = {31'b0, cfg.enable};  // Clear bit reads as 0
            REG_MAC_LO: o_prdata = cfg.local_mac[31:0];
            REG_MAC_HI: o_prdata = {16'b0, cfg.local_mac[47:32]};
            REG_IP:     o_prdata = cfg.local_ip;
            default: begin
                if (cnt_hit) begin
                    o_prdata = {16'b0, i_cnt[cnt_ofs[4:2]]};
                end
            end
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cfg       <= '0;
            cnt_clear <= 1'b0;
        end else begin
            cnt_clear <= 1'b0;
            if (wr_en) begin
                case (i_paddr)
                    REG_CTRL: begin
                        cfg.enable <= i_pwdata[0];
                        cnt_clear  <= i_pwdata[1];
                    end
                    REG_MAC_LO: cfg.local_mac[31:0]  <= i_pwdata;
                    REG_MAC_HI: cfg.local_mac[47:32] <= i_pwdata[15:0];
                    REG_IP:     cfg.local_ip         <= i_pwdata;
                    default:    ;
                endcase
            end
        end
    end

    assign o_cfg       = cfg;
    assign o_cnt_clear = cnt_clear;

    // Table write happens in the execute stage at this edge
    assign o_psn_load     = wr_en & psn_hit;
    assign o_psn_load_qp  = psn_ofs[4:2];
    assign o_psn_load_val = i_pwdata[23:0];

endmodule

`default_nettype wire

// ==== hw/roce_hdr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module roce_hdr_decode import roce_pkg::*; (
    input  wire            aclk,
    input  wire            aresetn,
    input  wire roce_cfg_t i_cfg,
    input  wire            i_rx_valid,
    input  wire rx_beat_t  i_rx_beat,
    output hdr_info_t      o_hdr
);

    typedef struct packed {
        mac_addr_t   mac_dst;
        logic [15:0] eth_type;
        ipv4_addr_t  ip_dst;
        logic [15:0] udp_dport;
        logic [7:0]  opcode;
        qpn_t        dest_qp;
        psn_t        psn;
        logic        full_hdr;
    } hdr_fields_t;

    logic        sof;
    logic        s1_valid;
    hdr_fields_t fields_in;
    hdr_fields_t s1_fields;
    logic        is_roce;
    logic        is_local;
    pkt_class_e  cls;

    // Network byte order field starting at byte ofs
    function automatic logic [47:0] be_field(input logic [BEAT_BYTES*8-1:0] data,
                                             input int ofs, input int len);
        logic [47:0] val;
        val = '0;
        for (int i = 0; i < len; i++) begin
            val = {val[39:0], data[8*(ofs+i) +: 8]};
        end
        return val;
    endfunction

    always_comb begin
        fields_in.mac_dst   = mac_addr_t'(be_field(i_rx_beat.data, OFS_ETH_DST, 6));
        fields_in.eth_type  = 16'(be_field(i_rx_beat.data, OFS_ETH_TYPE, 2));
        fields_in.ip_dst    = ipv4_addr_t'(be_field(i_rx_beat.data, OFS_IP_DST, 4));
        fields_in.udp_dport = 16'(be_field(i_rx_beat.data, OFS_UDP_DPORT, 2));
        fields_in.opcode    = 8'(be_field(i_rx_beat.data, OFS_BTH_OPCODE, 1));
        fields_in.dest_qp   = qpn_t'(be_field(i_rx_beat.data, OFS_BTH_DQP, 3));
        fields_in.psn       = psn_t'(be_field(i_rx_beat.data, OFS_BTH_PSN, 3));
        fields_in.full_hdr  = i_rx_beat.keep[HDR_BYTES-1];  // Runt frames are not RoCE
    end

    // Stage 1, capture header fields of the first beat
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sof      <= 1'b1;
            s1_valid <= 1'b0;
        end else begin
            if (i_rx_valid) begin
                sof <= i_rx_beat.last;
            end
            s1_valid <= i_rx_valid & sof & i_cfg.enable;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_rx_valid && sof) begin
            s1_fields <= fields_in;
        end
    end

    // Stage 2, compare against local config and sort by opcode
    assign is_roce  = s1_fields.full_hdr && (s1_fields.eth_type == ETH_TYPE_IPV4)
                      && (s1_fields.udp_dport == ROCE_UDP_PORT);
    assign is_local = (s1_fields.mac_dst == i_cfg.local_mac)
                      && (s1_fields.ip_dst == i_cfg.local_ip);

    always_comb begin
        if (!is_roce) begin
            cls = NON_ROCE;
        end else if (!is_local) begin
            cls = ADDR_DROP;
        end else begin
            case (s1_fields.opcode)
                OP_SEND_ONLY:      cls = SEND;
                OP_WRITE_ONLY:     cls = WRITE;
                OP_READ_RESP_ONLY: cls = READ_RESP;
                OP_ACK:            cls = ACK;
                default:           cls = ADDR_DROP;  // Unsupported opcode
            endcase
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_hdr <= '0;
        end else begin
            o_hdr <= '{valid: s1_valid, cls: cls, dest_qp: s1_fields.dest_qp,
                       psn: s1_fields.psn};
        end
    end

endmodule

`default_nettype wire

// ==== hw/roce_psn_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module roce_psn_execute import roce_pkg::*; #(
    parameter int NUM_QP = 6
) (
    input  wire             aclk,
    input  wire             aresetn,
    input  wire hdr_info_t  i_hdr,
    input  wire             i_psn_load,
    input  wire [2:0]       i_psn_load_qp,
    input  wire psn_t       i_psn_load_val,
    output pkt_event_t      o_event
);

    psn_t       exp_psn [NUM_QP];
    logic       in_range;
    logic [2:0] qp_idx;
    logic       checked;
    logic       accept;
    pkt_class_e cls;

    assign in_range = (i_hdr.dest_qp >= QP_BASE) && (i_hdr.dest_qp < QP_BASE + NUM_QP);
    assign qp_idx   = 3'(i_hdr.dest_qp - QP_BASE);
    assign checked  = i_hdr.cls inside {SEND, WRITE, READ_RESP, ACK};

    always_comb begin
        cls    = i_hdr.cls;
        accept = 1'b0;
        if (checked) begin
            if (!in_range) begin
                cls = BAD_QP;
            end else if (i_hdr.psn != exp_psn[qp_idx]) begin
                cls = PSN_ERR;
            end else begin
                accept = i_hdr.valid;
            end
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_event <= '0;
        end else begin
            o_event <= '{valid: i_hdr.valid, cls: cls, qp: i_hdr.dest_qp};
        end
    end

    // Updated on the same edge the event leaves, so a following frame sees it
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < NUM_QP; i++) begin
                exp_psn[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_QP; i++) begin
                if (i_psn_load && (i_psn_load_qp == 3'(i))) begin
                    exp_psn[i] <= i_psn_load_val;  // Software load wins
                end else if (accept && (qp_idx == 3'(i))) begin
                    exp_psn[i] <= exp_psn[i] + 24'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/roce_stat_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module roce_stat_result import roce_pkg::*; (
    input  wire              aclk,
    input  wire              aresetn,
    input  wire pkt_event_t  i_event,
    input  wire              i_cnt_clear,
    output pkt_event_t       o_event,
    output cnt_t [NUM_CLASS-1:0] o_cnt
);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_event <= '0;
        end else begin
            o_event <= i_event;
        end
    end

    // One saturating counter per class, indexed by enum value
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_cnt <= '0;
        end else begin
            for (int c = 0; c < NUM_CLASS; c++) begin
                if (i_cnt_clear) begin
                    o_cnt[c] <= '0;
                end else if (i_event.valid && (int'(i_event.cls) == c)
                             && (o_cnt[c] != '1)) begin
                    o_cnt[c] <= o_cnt[c] + 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/roce_rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module roce_rx_top import roce_pkg::*; #(
    parameter int NUM_QP = 6
) (
    input  wire             aclk,
    input  wire             aresetn,
    input  wire             i_rx_valid,
    input  wire rx_beat_t   i_rx_beat,
    input  wire             i_psel,
    input  wire             i_penable,
    input  wire             i_pwrite,
    input  wire apb_addr_t  i_paddr,
    input  wire apb_data_t  i_pwdata,
    output apb_data_t       o_prdata,
    output logic            o_pready,
    output logic            o_pslverr,
    output pkt_event_t      o_event
);

    roce_cfg_t            cfg;
    logic                 psn_load;
    logic [2:0]           psn_load_qp;
    psn_t                 psn_load_val;
    logic                 cnt_clear;
    hdr_info_t            hdr;
    pkt_event_t           exec_event;
    cnt_t [NUM_CLASS-1:0] cnt;

    roce_cfg_regs #(
        .NUM_QP (NUM_QP)
    ) cfg_regs_i (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_psel         (i_psel),
        .i_penable      (i_penable),
        .i_pwrite       (i_pwrite),
        .i_paddr        (i_paddr),
        .i_pwdata       (i_pwdata),
        .i_cnt          (cnt),
        .o_prdata       (o_prdata),
        .o_pready       (o_pready),
        .o_pslverr      (o_pslverr),
        .o_cfg          (cfg),
        .o_psn_load     (psn_load),
        .o_psn_load_qp  (psn_load_qp),
        .o_psn_load_val (psn_load_val),
        .o_cnt_clear    (cnt_clear)
    );

    // Decode, two cycles
    roce_hdr_decode hdr_decode_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_cfg      (cfg),
        .i_rx_valid (i_rx_valid),
        .i_rx_beat  (i_rx_beat),
        .o_hdr      (hdr)
    );

    roce_psn_execute #(
        .NUM_QP (NUM_QP)
    ) psn_execute_i (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_hdr          (hdr),
        .i_psn_load     (psn_load),
        .i_psn_load_qp  (psn_load_qp),
        .i_psn_load_val (psn_load_val),
        .o_event        (exec_event)
    );

    roce_stat_result stat_result_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_event     (exec_event),
        .i_cnt_clear (cnt_clear),
        .o_event     (o_event),
        .o_cnt       (cnt)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;  // 4 ns period
    end

    // Release away from the rising edge
    initial begin
        aresetn = 1'b0;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_checker import roce_pkg::*; (
    input  wire             aclk,
    input  wire pkt_event_t i_event,
    input  wire             i_psel,
    input  wire             i_penable,
    input  wire             i_pwrite,
    input  wire apb_data_t  i_prdata,
    input  wire             i_pready,
    input  wire             i_pslverr
);

    string      ev_name_q[$];
    pkt_class_e ev_cls_q[$];
    qpn_t       ev_qp_q[$];
    string      rd_name_q[$];
    apb_data_t  rd_data_q[$];
    logic       rd_err_q[$];

    int pass_count   = 0;
    int err_count    = 0;
    int expect_count = 0;  // Bumped by the stimulus side
    int done_count   = 0;

    task automatic expect_event(input string name, input pkt_class_e cls, input qpn_t qp);
        ev_name_q.push_back(name);
        ev_cls_q.push_back(cls);
        ev_qp_q.push_back(qp);
        expect_count++;
    endtask

    task automatic expect_read(input string name, input apb_data_t data, input logic err);
        rd_name_q.push_back(name);
        rd_data_q.push_back(data);
        rd_err_q.push_back(err);
        expect_count++;
    endtask

    // Events and APB reads both land here, in arrival order
    always @(posedge aclk) begin : compare
        string      name;
        pkt_class_e cls;
        pkt_class_e act_cls;
        qpn_t       qp;
        apb_data_t  data;
        logic       err;
        act_cls = i_event.cls;
        if (i_event.valid) begin
            if (ev_name_q.size() == 0) begin
                $display("Unexpected event of class %s for QP %0d with no frame outstanding",
                         act_cls.name(), i_event.qp);
                err_count++;
            end else begin
                name = ev_name_q.pop_front();
                cls  = ev_cls_q.pop_front();
                qp   = ev_qp_q.pop_front();
                if ((act_cls != cls) || (i_event.qp != qp)) begin
                    $display("Mismatch %s: expected class=%s qp=%0d, actual class=%s qp=%0d",
                             name, cls.name(), qp, act_cls.name(), i_event.qp);
                    err_count++;
                end else begin
                    $display("ok %s class=%s qp=%0d", name, cls.name(), qp);
                    pass_count++;
                end
                done_count++;
            end
        end
        // Zero wait states on every transfer
        if (i_psel && i_penable && (i_pready !== 1'b1)) begin
            $display("APB access at %0t finished without pready high", $time);
            err_count++;
        end
        if (i_psel && i_penable && !i_pwrite) begin
            if (rd_name_q.size() == 0) begin
                $display("APB read at %0t was not announced to the checker", $time);
                err_count++;
            end else begin
                name = rd_name_q.pop_front();
                data = rd_data_q.pop_front();
                err  = rd_err_q.pop_front();
                if ((i_prdata !== data) || (i_pslverr !== err)) begin
                    $display("Mismatch %s: expected data=%h err=%b, actual data=%h err=%b",
                             name, data, err, i_prdata, i_pslverr);
                    err_count++;
                end else begin
                    $display("ok %s data=%h err=%b", name, data, err);
                    pass_count++;
                end
                done_count++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_top import roce_pkg::*; ();

    localparam int          NUM_QP    = 6;
    localparam mac_addr_t   LOCAL_MAC = 48'h02_11_22_33_44_55;
    localparam ipv4_addr_t  LOCAL_IP  = 32'hC0A8_0A0B;
    localparam logic [15:0] ETH_OK    = ETH_TYPE_IPV4;
    localparam logic [15:0] UDP_OK    = ROCE_UDP_PORT;

    typedef struct packed {
        logic        en;  // Sent before enable is set when 0
        logic        mac_ok;
        logic        ip_ok;
        logic [15:0] eth_type;
        logic [15:0] udp_port;
        logic [7:0]  opcode;
        qpn_t        qp;
        psn_t        psn;
        logic [3:0]  beats;
        pkt_class_e  cls;
    } frame_row_t;

    logic       aclk;
    logic       aresetn;
    logic       rx_valid;
    rx_beat_t   rx_beat;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    apb_data_t  pwdata;
    apb_data_t  prdata;
    logic       pready;
    logic       pslverr;
    pkt_event_t dut_event;

    frame_row_t rows[$];
    string      row_names[$];
    psn_t       psn_init [NUM_QP];
    int         exp_cnt [NUM_CLASS];
    integer     seed   = 63355;
    int         cycles = 0;
    int         limit  = 0;

    tb_clk_gen clk_gen_i (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    roce_rx_top dut_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_rx_valid (rx_valid),
        .i_rx_beat  (rx_beat),
        .i_psel     (psel),
        .i_penable  (penable),
        .i_pwrite   (pwrite),
        .i_paddr    (paddr),
        .i_pwdata   (pwdata),
        .o_prdata   (prdata),
        .o_pready   (pready),
        .o_pslverr  (pslverr),
        .o_event    (dut_event)
    );

    tb_checker chk_i (
        .aclk      (aclk),
        .i_event   (dut_event),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_prdata  (prdata),
        .i_pready  (pready),
        .i_pslverr (pslverr)
    );

    task automatic add_row(input string name, input logic en, input logic mac_ok,
                           input logic ip_ok, input logic [15:0] eth_type,
                           input logic [15:0] udp_port, input logic [7:0] opcode,
                           input qpn_t qp, input psn_t psn, input int beats,
                           input pkt_class_e cls);
        rows.push_back('{en, mac_ok, ip_ok, eth_type, udp_port, opcode, qp, psn,
                         4'(beats), cls});
        row_names.push_back(name);
    endtask

    task automatic build_table();
        psn_init = '{24'd100, 24'hFFFFFE, 24'd200, 24'd300, 24'd400, 24'd500};
        add_row("disabled_send", 0, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 2, 0, 1, SEND);
        add_row("disabled_multi", 0, 1, 1, ETH_OK, UDP_OK, OP_WRITE_ONLY, 4, 0, 2, WRITE);
        add_row("non_roce_ethtype", 1, 1, 1, 16'h86DD, UDP_OK, OP_SEND_ONLY, 2, 100, 1, NON_ROCE);
        add_row("non_roce_udp", 1, 1, 1, ETH_OK, 16'd4792, OP_SEND_ONLY, 2, 100, 1, NON_ROCE);
        add_row("addr_drop_mac", 1, 0, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 2, 100, 1, ADDR_DROP);
        add_row("addr_drop_ip", 1, 1, 0, ETH_OK, UDP_OK, OP_SEND_ONLY, 2, 100, 1, ADDR_DROP);
        add_row("send_qp2", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 2, 100, 1, SEND);
        add_row("write_qp4", 1, 1, 1, ETH_OK, UDP_OK, OP_WRITE_ONLY, 4, 200, 1, WRITE);
        add_row("read_resp_qp5", 1, 1, 1, ETH_OK, UDP_OK, OP_READ_RESP_ONLY, 5, 300, 1, READ_RESP);
        add_row("ack_qp6", 1, 1, 1, ETH_OK, UDP_OK, OP_ACK, 6, 400, 1, ACK);
        // PSN wraps through zero on QP 3
        add_row("seq_qp3_a", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 3, 'hFFFFFE, 1, SEND);
        add_row("seq_qp3_b", 1, 1, 1, ETH_OK, UDP_OK, OP_WRITE_ONLY, 3, 'hFFFFFF, 1, WRITE);
        add_row("seq_qp3_c", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 3, 0, 1, SEND);
        add_row("seq_qp3_dup", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 3, 0, 1, PSN_ERR);
        add_row("seq_qp3_d", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 3, 1, 1, SEND);
        add_row("bad_qp_zero", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 0, 0, 1, BAD_QP);
        add_row("bad_qp_low", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 1, 0, 1, BAD_QP);
        add_row("bad_qp_high", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 8, 0, 1, BAD_QP);
        add_row("ack_qp7", 1, 1, 1, ETH_OK, UDP_OK, OP_ACK, 7, 500, 1, ACK);
        add_row("multi_beat_send", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 2, 101, 3, SEND);
        add_row("multi_beat_dup", 1, 1, 1, ETH_OK, UDP_OK, OP_SEND_ONLY, 2, 101, 2, PSN_ERR);
        add_row("multi_beat_write", 1, 1, 1, ETH_OK, UDP_OK, OP_WRITE_ONLY, 2, 102, 4, WRITE);
        add_row("unknown_opcode", 1, 1, 1, ETH_OK, UDP_OK, 8'h64, 2, 103, 1, ADDR_DROP);
    endtask

    // Big endian field into the beat, byte 0 in bits 7:0
    function automatic logic [BEAT_BYTES*8-1:0] put_be(input logic [BEAT_BYTES*8-1:0] data,
                                                      input int ofs, input int len,
                                                      input logic [47:0] val);
        for (int i = 0; i < len; i++) begin
            data[8*(ofs+i) +: 8] = val[8*(len-1-i) +: 8];
        end
        return data;
    endfunction

    function automatic rx_beat_t build_beat(input frame_row_t row, input int b);
        rx_beat_t   beat;
        mac_addr_t  mac;
        ipv4_addr_t ip;
        for (int k = 0; k < BEAT_BYTES / 4; k++) begin
            beat.data[32*k +: 32] = $random(seed);
        end
        beat.keep = '1;
        beat.last = (b == row.beats - 1);
        if (b == 0) begin
            mac = row.mac_ok ? LOCAL_MAC : (LOCAL_MAC ^ 48'h1);
            ip  = row.ip_ok ? LOCAL_IP : (LOCAL_IP ^ 32'h100);
            beat.data = put_be(beat.data, OFS_ETH_DST, 6, mac);
            beat.data = put_be(beat.data, OFS_ETH_TYPE, 2, row.eth_type);
            beat.data = put_be(beat.data, OFS_IP_DST, 4, ip);
            beat.data = put_be(beat.data, OFS_UDP_DPORT, 2, row.udp_port);
            beat.data = put_be(beat.data, OFS_BTH_OPCODE, 1, row.opcode);
            beat.data = put_be(beat.data, OFS_BTH_DQP, 3, row.qp);
            beat.data = put_be(beat.data, OFS_BTH_PSN, 3, row.psn);
        end
        return beat;
    endfunction

    task automatic send_frame(input int idx);
        frame_row_t row;
        row = rows[idx];
        for (int b = 0; b < int'(row.beats); b++) begin
            @(negedge aclk);
            rx_valid = 1'b1;
            rx_beat  = build_beat(row, b);
        end
    endtask

    task automatic stop_stream();
        @(negedge aclk);
        rx_valid = 1'b0;
        rx_beat  = '0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(negedge aclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge aclk);
        penable = 1'b1;
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input string name, input apb_addr_t addr,
                            input apb_data_t exp_data, input logic exp_err);
        chk_i.expect_read(name, exp_data, exp_err);
        @(negedge aclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge aclk);
        penable = 1'b1;
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_counters(input string tag, input logic zero);
        pkt_class_e cls_v;
        for (int c = 0; c < NUM_CLASS; c++) begin
            cls_v = pkt_class_e'(c);
            apb_read($sformatf("%s_cnt_%s", tag, cls_v.name()), REG_CNT_BASE + apb_addr_t'(4 * c),
                     zero ? 32'd0 : apb_data_t'(exp_cnt[c]), 1'b0);
        end
    endtask

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if ((limit != 0) && (cycles >= limit)) begin
            $display("Timeout after %0d cycles with %0d results still outstanding", cycles,
                     chk_i.expect_count - chk_i.done_count);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        int total_beats;
        rx_valid = 1'b0;
        rx_beat  = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        build_table();
        total_beats = 0;
        for (int c = 0; c < NUM_CLASS; c++) begin
            exp_cnt[c] = 0;
        end
        foreach (rows[i]) begin
            total_beats += int'(rows[i].beats);
            if (rows[i].en) begin
                exp_cnt[int'(rows[i].cls)]++;
            end
        end
        limit = 3 * total_beats + 200;
        @(posedge aresetn);

        // Enable still off, nothing may come out
        foreach (rows[i]) begin
            if (!rows[i].en) begin
                send_frame(i);
            end
        end
        stop_stream();
        check_counters("off", 1'b1);

        apb_write(REG_MAC_LO, LOCAL_MAC[31:0]);
        apb_write(REG_MAC_HI, {16'b0, LOCAL_MAC[47:32]});
        apb_write(REG_IP, LOCAL_IP);
        for (int q = 0; q < NUM_QP; q++) begin
            apb_write(REG_PSN_BASE + apb_addr_t'(4 * q), {8'b0, psn_init[q]});
        end
        apb_write(REG_CTRL, 32'h1);
        apb_read("reg_ctrl", REG_CTRL, 32'h1, 1'b0);
        apb_read("reg_mac_lo", REG_MAC_LO, LOCAL_MAC[31:0], 1'b0);
        apb_read("reg_mac_hi", REG_MAC_HI, {16'b0, LOCAL_MAC[47:32]}, 1'b0);
        apb_read("reg_ip", REG_IP, LOCAL_IP, 1'b0);

        // Frames go back to back
        foreach (rows[i]) begin
            if (rows[i].en) begin
                chk_i.expect_event(row_names[i], rows[i].cls, rows[i].qp);
                send_frame(i);
            end
        end
        stop_stream();
        wait (chk_i.done_count == chk_i.expect_count);

        check_counters("run", 1'b0);
        apb_write(REG_CTRL, 32'h3);  // Keep enable, pulse clear
        check_counters("clear", 1'b1);
        apb_read("unmapped", 12'h100, 32'd0, 1'b1);
        wait (chk_i.done_count == chk_i.expect_count);
        repeat (8) @(negedge aclk);

        $display("Counts: %0d checks passed, %0d errors", chk_i.pass_count, chk_i.err_count);
        if (chk_i.err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/roce_pkg.sv
hw/roce_cfg_regs.sv
hw/roce_hdr_decode.sv
hw/roce_psn_execute.sv
hw/roce_stat_result.sv
hw/roce_rx_top.sv
testbench/tb_clk_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== Bender.yml ====
package:
  name: roce_rx

sources:
  - files:
      - hw/roce_pkg.sv
      - hw/roce_cfg_regs.sv
      - hw/roce_hdr_decode.sv
      - hw/roce_psn_execute.sv
      - hw/roce_stat_result.sv
      - hw/roce_rx_top.sv

  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_checker.sv
      - testbench/tb_top.sv
